// File: all.f
+incdir+source
source/qla_pkg.sv
source/ctrl_dac.sv
source/ctrl_enc.sv
source/board_regs.sv
source/qla_top.sv
sim/tb_clk_gen.sv
sim/qla_asserts.sv
sim/qla_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module qla_tb -f all.f -Mdir obj_dir -o qla_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/qla_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: sim/qla_asserts.sv
// concurrent checks on the qla_top pins and their bind into the top level
`timescale 1ns/1ns
`include "qla_macros.svh"

module qla_asserts (
    input logic                         sysclk,
    input logic                         rst_n,
    input logic [`QLA_ADDR_BITS-1:0]    reg_addr,
    input logic                         reg_wen,
    input logic [`QLA_DATA_BITS-1:0]    reg_rdata,
    input logic                         dac_sclk,
    input logic                         dac_mosi,
    input logic                         dac_csel
);

    logic dac_wr;           // setpoint write on this edge
    logic dac_written;      // any setpoint write since reset

    assign dac_wr = reg_wen && (reg_addr[3:0] == `QLA_DEV_DAC) &&
                    (reg_addr[7:4] >= 4'd1) && (reg_addr[7:4] <= 4'(`QLA_NUM_CHAN));

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            dac_written <= 1'b0;
        end else if (dac_wr) begin
            dac_written <= 1'b1;
        end
    end

    // --------------------
    // properties
    // --------------------
    csel_idle: assert property (@(posedge sysclk) disable iff (!rst_n)
        !dac_written |-> dac_csel)
        else $error("dac_csel went low before any DAC setpoint write");

    // dac samples on the rising sclk and needs data held while sclk is high
    mosi_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        dac_sclk |-> $stable(dac_mosi))
        else $error("dac_mosi changed while dac_sclk was high");

    rdata_known: assert property (@(posedge sysclk) disable iff (!rst_n)
        !$isunknown(reg_rdata))
        else $error("reg_rdata has unknown bits");

endmodule

bind qla_top qla_asserts u_asserts (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .reg_addr  (reg_addr),
    .reg_wen   (reg_wen),
    .reg_rdata (reg_rdata),
    .dac_sclk  (dac_sclk),
    .dac_mosi  (dac_mosi),
    .dac_csel  (dac_csel)
);

// File: sim/qla_tb.sv
// testbench top with stimulus, register model, read compare, dac frame monitor and watchdog
`timescale 1ns/1ns
`include "qla_macros.svh"

module qla_tb;

    localparam int CLK_NS     = 20;
    localparam int DAC_WRITES = 6;
    localparam int ENC_STEPS  = 40;
    localparam int ENC_ROUNDS = 3;
    localparam int FRAME_CYC  = 2 * `QLA_DAC_FRAME_BITS + 6;   // sclk at sysclk/2, plus gap
    // rough length of each test in cycles
    localparam int TEST_CYC   = 10                                 // reset values
                              + 6 * 4 + 30                         // board control, fault
                              + DAC_WRITES * (FRAME_CYC + 10)      // setpoint readback
                              + 5 * FRAME_CYC + 20                 // frame order
                              + ENC_ROUNDS * (ENC_STEPS + 40);     // encoders
    localparam int TIMEOUT_NS = (TEST_CYC + 200) * CLK_NS;

    logic        sysclk;
    logic        rst_n;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic [31:0] reg_rdata;
    logic [3:0]  enc_a;
    logic [3:0]  enc_b;
    logic [3:0]  board_id;
    logic [3:0]  fault;
    logic [3:0]  home;
    logic [3:0]  pos_limit;
    logic [3:0]  neg_limit;
    logic        dac_sclk;
    logic        dac_mosi;
    logic        dac_csel;
    logic [3:0]  amp_disable;
    logic        pwr_enable;
    logic        relay_on;

    // --------------------
    // register model
    // --------------------
    logic [3:0]  m_amp_en;          // 1 = amp on
    logic        m_pwr;
    logic        m_relay;
    logic [15:0] m_dac [4];
    logic [23:0] m_cnt [4];
    logic [23:0] m_pre [4];
    logic [1:0]  m_pos [4];         // quadrature phase per axis

    logic [7:0]  rd_addr_q [$];     // reads waiting for the compare
    logic [31:0] rd_exp_q [$];
    logic [23:0] exp_frames [$];    // dac frames in send order

    tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk (.clk(sysclk));

    qla_top u_dut (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .reg_rdata   (reg_rdata),
        .enc_a       (enc_a),
        .enc_b       (enc_b),
        .board_id    (board_id),
        .fault       (fault),
        .home        (home),
        .pos_limit   (pos_limit),
        .neg_limit   (neg_limit),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable),
        .relay_on    (relay_on)
    );

    // expected read word for an address, from the model
    function automatic logic [31:0] expect_read(logic [7:0] addr);
        logic [3:0]  chan;
        logic [3:0]  dev;
        logic [31:0] word;
        int          idx;
        chan = addr[7:4];
        dev  = addr[3:0];
        idx  = int'(chan) - 1;
        word = '0;
        if (chan == 4'd0) begin
            if (dev == `QLA_BREG_STATUS) begin
                word = {4'h0, board_id, fault, 4'h0, home, pos_limit, neg_limit, m_amp_en};
            end else if (dev == `QLA_BREG_ID) begin
                word = `QLA_BOARD_ID_WORD;
            end
        end else if (chan <= 4'd4) begin
            if (dev == `QLA_DEV_DAC) begin
                word = {16'h0, m_dac[idx]};
            end else if (dev == `QLA_DEV_PRELOAD) begin
                word = {8'h0, m_pre[idx]};              // preload reads unsigned
            end else if (dev == `QLA_DEV_QUAD) begin
                word = {{8{m_cnt[idx][23]}}, m_cnt[idx]};
            end
        end
        return word;
    endfunction

    // phase 0..3 to {a, b}, a leads b going up
    function automatic logic [1:0] gray_ab(logic [1:0] pos);
        case (pos)
            2'd0:    return 2'b00;
            2'd1:    return 2'b10;
            2'd2:    return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    task automatic report_fail(string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else report_fail($sformatf("Fail time=%0t %s got=%0h exp=%0h", $time, name, got, exp));
    endtask

    task automatic check_pins();
        check_val("amp_disable", {28'h0, amp_disable}, {28'h0, ~m_amp_en});
        check_val("pwr_enable", {31'h0, pwr_enable}, {31'h0, m_pwr});
        check_val("relay_on", {31'h0, relay_on}, {31'h0, m_relay});
    endtask

    // one-cycle write strobe
    task automatic bus_write(logic [7:0] addr, logic [31:0] data);
        @(negedge sysclk);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(negedge sysclk);
        reg_wen   = 1'b0;
    endtask

    // hold the address for a cycle, compare runs mid low phase
    task automatic bus_read(logic [7:0] addr);
        @(negedge sysclk);
        reg_addr = addr;
        rd_addr_q.push_back(addr);
        rd_exp_q.push_back(expect_read(addr));
    endtask

    task automatic wait_dac_done();
        while (exp_frames.size() != 0) begin
            @(negedge sysclk);
        end
        repeat (3) @(negedge sysclk);       // csel gap
    endtask

    // one random step on every axis, some illegal double steps
    task automatic step_encoders();
        logic [1:0] delta;
        logic [1:0] ab;
        int         r;
        for (int i = 0; i < 4; i++) begin
            r = $urandom_range(0, 9);
            if (r < 4) begin
                delta = 2'd1;               // up
            end else if (r < 8) begin
                delta = 2'd3;               // down
            end else if (r == 8) begin
                delta = 2'd2;               // a and b together, no count
            end else begin
                delta = 2'd0;
            end
            m_pos[i] = m_pos[i] + delta;
            if (delta == 2'd1) begin
                m_cnt[i] = m_cnt[i] + 24'd1;
            end else if (delta == 2'd3) begin
                m_cnt[i] = m_cnt[i] - 24'd1;
            end
            ab       = gray_ab(m_pos[i]);
            enc_a[i] = ab[1];
            enc_b[i] = ab[0];
        end
    endtask

    // --------------------
    // compare and monitor
    // --------------------
    initial begin : read_compare
        logic [7:0]  addr;
        logic [31:0] exp;
        forever begin
            @(negedge sysclk);
            #(CLK_NS / 4);
            while (rd_exp_q.size() > 0) begin
                addr = rd_addr_q.pop_front();
                exp  = rd_exp_q.pop_front();
                assert (reg_rdata === exp)
                else report_fail($sformatf("Fail time=%0t reg_rdata addr=%02h got=%08h exp=%08h",
                                           $time, addr, reg_rdata, exp));
            end
        end
    end

    // frame bits taken on rising sclk, msb first
    initial begin : dac_monitor
        logic [23:0] frame;
        logic [23:0] exp;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge dac_csel);
            frame = '0;
            for (int b = 0; b < `QLA_DAC_FRAME_BITS; b++) begin
                @(posedge dac_sclk);
                frame = {frame[22:0], dac_mosi};
            end
            assert (exp_frames.size() != 0)
            else report_fail($sformatf("DAC frame %06h was sent with no setpoint write behind it",
                                       frame));
            exp = exp_frames.pop_front();
            assert (frame === exp)
            else report_fail($sformatf("Fail time=%0t dac_frame got=%06h exp=%06h",
                                       $time, frame, exp));
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "run ended by the watchdog");
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin : stimulus
        int unsigned seed;
        logic [31:0] data;
        logic [3:0]  ch;
        int          idx;
        int          k;
        logic [15:0] v0;
        logic [15:0] v1;
        logic [15:0] v2a;
        logic [15:0] v2b;
        logic [15:0] v3;
        seed      = $urandom(29191);
        rst_n     = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        enc_a     = '0;
        enc_b     = '0;
        fault     = '0;
        board_id  = 4'($urandom);
        home      = 4'($urandom);
        pos_limit = 4'($urandom);
        neg_limit = 4'($urandom);
        m_amp_en  = '0;
        m_pwr     = 1'b0;
        m_relay   = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m_dac[i] = '0;
            m_cnt[i] = '0;
            m_pre[i] = '0;
            m_pos[i] = '0;
        end
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;

        // reset values
        check_pins();
        bus_read({4'h0, `QLA_BREG_STATUS});
        bus_read({4'h0, `QLA_BREG_ID});
        for (int c = 1; c <= 4; c++) begin
            bus_read({4'(c), `QLA_DEV_DAC});
            bus_read({4'(c), `QLA_DEV_QUAD});
        end

        // board control writes
        for (int n = 0; n < 6; n++) begin
            data = $urandom;
            bus_write({4'h0, `QLA_BREG_STATUS}, data);
            m_amp_en = data[3:0];
            m_pwr    = data[8];
            m_relay  = data[9];
            check_pins();
            bus_read({4'h0, `QLA_BREG_STATUS});
        end

        // fault interlock, latches off
        bus_write({4'h0, `QLA_BREG_STATUS}, 32'h0000_030F);
        m_amp_en = 4'hF;
        m_pwr    = 1'b1;
        m_relay  = 1'b1;
        k = $urandom_range(0, 3);
        @(negedge sysclk);
        fault[k] = 1'b1;
        repeat (3) @(posedge sysclk);           // two sync flops + interlock
        @(negedge sysclk);
        m_amp_en[k] = 1'b0;
        check_pins();
        bus_read({4'h0, `QLA_BREG_STATUS});     // fault field set
        @(negedge sysclk);
        fault[k] = 1'b0;
        repeat (4) @(negedge sysclk);
        check_pins();
        bus_read({4'h0, `QLA_BREG_STATUS});

        // setpoint readback, one frame each
        for (int n = 0; n < DAC_WRITES; n++) begin
            ch   = 4'($urandom_range(1, 4));
            idx  = int'(ch) - 1;
            data = $urandom;
            bus_write({ch, `QLA_DEV_DAC}, data);
            m_dac[idx] = data[15:0];
            exp_frames.push_back({`QLA_DAC_CMD, 4'(idx), data[15:0]});
            bus_read({ch, `QLA_DEV_DAC});
            bus_read({ch, 4'h2});                               // no device
            bus_read({4'($urandom_range(5, 15)), `QLA_DEV_DAC});  // no such axis
            bus_read(8'h01);                                    // unused board reg
            wait_dac_done();
        end

        // frame order while the shifter is busy
        v0  = 16'($urandom);
        v1  = 16'($urandom);
        v2a = 16'($urandom);
        v2b = ~v2a;
        v3  = 16'($urandom);
        bus_write(8'h21, {16'h0, v1});          // starts right away
        exp_frames.push_back({`QLA_DAC_CMD, 4'd1, v1});
        bus_write(8'h41, {16'h0, v3});
        bus_write(8'h31, {16'h0, v2a});
        bus_write(8'h11, {16'h0, v0});
        bus_write(8'h31, {16'h0, v2b});         // replaces the pending value
        exp_frames.push_back({`QLA_DAC_CMD, 4'd0, v0});
        exp_frames.push_back({`QLA_DAC_CMD, 4'd2, v2b});
        exp_frames.push_back({`QLA_DAC_CMD, 4'd3, v3});
        m_dac[0] = v0;
        m_dac[1] = v1;
        m_dac[2] = v2b;
        m_dac[3] = v3;
        bus_read(8'h31);
        wait_dac_done();

        // encoders, random walk then preload
        for (int r = 0; r < ENC_ROUNDS; r++) begin
            for (int s = 0; s < ENC_STEPS; s++) begin
                @(negedge sysclk);
                step_encoders();
            end
            repeat (4) @(negedge sysclk);       // sync + count update
            for (int c = 1; c <= 4; c++) begin
                bus_read({4'(c), `QLA_DEV_QUAD});
            end
            for (int c = 1; c <= 4; c++) begin
                data = $urandom;
                bus_write({4'(c), `QLA_DEV_PRELOAD}, data);
                m_pre[c - 1] = data[23:0];
                m_cnt[c - 1] = data[23:0];
                bus_read({4'(c), `QLA_DEV_PRELOAD});
                bus_read({4'(c), `QLA_DEV_QUAD});
            end
        end

        repeat (3) @(negedge sysclk);           // last compare
        $display("All checks passed");
        $finish;
    end

endmodule

// File: sim/tb_clk_gen.sv
// testbench clock source, free running
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS = 20        // full period
)(
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;    // 50% duty
        end
    end

endmodule

// File: source/board_regs.sv
// channel-0 status and control registers, amplifier fault interlock, read-data router
`timescale 1ns/1ns
`include "qla_macros.svh"

module board_regs
    import qla_pkg::*;
(
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  qla_addr_u                   reg_addr,
    input  logic [`QLA_DATA_BITS-1:0]   reg_wdata,
    input  logic                        reg_wen,
    input  logic [`QLA_NUM_CHAN-1:0]    board_id,
    input  logic [`QLA_NUM_CHAN-1:0]    fault,
    input  logic [`QLA_NUM_CHAN-1:0]    home,
    input  logic [`QLA_NUM_CHAN-1:0]    pos_limit,
    input  logic [`QLA_NUM_CHAN-1:0]    neg_limit,
    input  logic [`QLA_DATA_BITS-1:0]   dac_rdata,
    input  logic [`QLA_DATA_BITS-1:0]   enc_rdata,
    output logic [`QLA_DATA_BITS-1:0]   reg_rdata,
    output logic [`QLA_NUM_CHAN-1:0]    amp_disable,
    output logic                        pwr_enable,
    output logic                        relay_on
);

    localparam int N = `QLA_NUM_CHAN;

    logic [N-1:0]               fault_s1, fault_s2;     // 2-flop sync
    logic [N-1:0]               amp_en;                 // enable mask, 1 = on
    logic                       is_chan0;
    logic                       stat_wr;
    logic [`QLA_DATA_BITS-1:0]  status_word;
    logic [`QLA_DATA_BITS-1:0]  chan0_rdata;

    // board view only valid when the high nibble is zero
    assign is_chan0 = (reg_addr.board.zero == 4'd0);
    assign stat_wr  = reg_wen && is_chan0 && (reg_addr.board.idx == `QLA_BREG_STATUS);

    // --------------------
    // control + interlock
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            fault_s1   <= '0;
            fault_s2   <= '0;
            amp_en     <= '0;               // all amps off
            pwr_enable <= 1'b0;
            relay_on   <= 1'b0;
        end else begin
            fault_s1 <= fault;
            fault_s2 <= fault_s1;
            if (stat_wr) begin
                amp_en     <= reg_wdata[N-1:0] & ~fault_s2;    // no re-enable under fault
                pwr_enable <= reg_wdata[8];
                relay_on   <= reg_wdata[9];
            end else begin
                amp_en <= amp_en & ~fault_s2;   // latches off, host must re-enable
            end
        end
    end

    // synced fault has already cleared the enable bit, so it stays off
    assign amp_disable = ~amp_en;

    // --------------------
    // read side
    // --------------------
    assign status_word = {4'h0,             // 31:28 unused
                          board_id,         // 27:24
                          fault_s2,         // 23:20
                          4'h0,             // 19:16 unused
                          home,
                          pos_limit,
                          neg_limit,
                          amp_en};

    always_comb begin
        case (reg_addr.board.idx)
            `QLA_BREG_STATUS: chan0_rdata = status_word;
            `QLA_BREG_ID:     chan0_rdata = `QLA_BOARD_ID_WORD;
            default:          chan0_rdata = '0;
        endcase
    end

    // channel 0 own regs, axes routed by device nibble
    always_comb begin
        if (is_chan0) begin
            reg_rdata = chan0_rdata;
        end else begin
            case (reg_addr.axis.dev)
                `QLA_DEV_DAC:     reg_rdata = dac_rdata;
                `QLA_DEV_PRELOAD: reg_rdata = enc_rdata;
                `QLA_DEV_QUAD:    reg_rdata = enc_rdata;
                default:          reg_rdata = '0;      // unmapped
            endcase
        end
    end

endmodule

// File: source/ctrl_dac.sv
// dac setpoint registers, pending-write tracker and shared serial frame shifter
`timescale 1ns/1ns
`include "qla_macros.svh"

module ctrl_dac
    import qla_pkg::*;
#(
    parameter int DAC_DIV = 1                       // sclk half-period in sysclk cycles
)(
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  qla_addr_u                   reg_addr,
    input  logic [`QLA_DATA_BITS-1:0]   reg_wdata,
    input  logic                        reg_wen,
    output logic [`QLA_DATA_BITS-1:0]   dac_rdata,
    output logic                        dac_sclk,
    output logic                        dac_mosi,
    output logic                        dac_csel
);

    localparam int N      = `QLA_NUM_CHAN;
    localparam int CH_W   = `QLA_CHAN_BITS;
    localparam int FRM_W  = `QLA_DAC_FRAME_BITS;
    localparam int DIV_W  = (DAC_DIV > 1) ? $clog2(DAC_DIV) : 1;
    localparam int BCNT_W = $clog2(FRM_W);

    // shifter states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SHIFT = 2'd1;
    localparam logic [1:0] ST_GAP   = 2'd2;     // extra csel-high cycle

    logic [`QLA_DAC_BITS-1:0] dac_set [N];      // setpoints
    logic [N-1:0]             pending;          // written, not yet sent
    logic [N-1:0]             pend_set;
    logic [N-1:0]             pend_clr;
    logic                     set_wr;
    logic [CH_W-1:0]          wr_ch;

    logic [CH_W-1:0]          next_ch;          // lowest pending
    logic                     have_pend;
    logic                     load;
    logic [FRM_W-1:0]         frame;

    logic [1:0]               state;
    logic [FRM_W-1:0]         shift_reg;
    logic [BCNT_W-1:0]        bit_cnt;          // bits left after current one
    logic [DIV_W-1:0]         div_cnt;
    logic                     div_end;
    logic                     shift_tick;       // falling sclk, more bits to go

    // --------------------
    // host writes
    // --------------------
    assign wr_ch  = axis_index(reg_addr);
    assign set_wr = reg_wen && axis_valid(reg_addr) && (reg_addr.axis.dev == `QLA_DEV_DAC);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                dac_set[i] <= '0;
            end
        end else if (set_wr) begin
            dac_set[wr_ch] <= reg_wdata[`QLA_DAC_BITS-1:0];    // newest value wins
        end
    end

    // readback, zero-extended, unmapped channels read 0
    assign dac_rdata = axis_valid(reg_addr) ?
                       {{(`QLA_DATA_BITS-`QLA_DAC_BITS){1'b0}}, dac_set[wr_ch]} : '0;

    // --------------------
    // pending mask
    // --------------------
    always_comb begin
        next_ch   = '0;
        have_pend = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin   // last hit is the lowest
            if (pending[i]) begin
                next_ch   = CH_W'(i);
                have_pend = 1'b1;
            end
        end
    end

    assign load  = (state == ST_IDLE) && have_pend;
    assign frame = {`QLA_DAC_CMD, 4'(next_ch), dac_set[next_ch]};

    always_comb begin
        pend_set = '0;
        pend_clr = '0;
        if (set_wr) pend_set[wr_ch] = 1'b1;
        if (load) pend_clr[next_ch] = 1'b1;
    end

    // a write landing on the load edge stays pending
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~pend_clr) | pend_set;
        end
    end

    // --------------------
    // frame shifter
    // --------------------
    assign div_end    = (div_cnt == DIV_W'(DAC_DIV - 1));
    assign shift_tick = (state == ST_SHIFT) && div_end && dac_sclk && (bit_cnt != '0);

    always_ff @(posedge sysclk) begin
        if (load) begin
            shift_reg <= frame;
        end else if (shift_tick) begin
            shift_reg <= shift_reg << 1;            // msb first
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            div_cnt  <= '0;
            dac_sclk <= 1'b0;
            dac_mosi <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        dac_csel <= 1'b0;
                        dac_mosi <= frame[FRM_W-1];  // first bit during sclk low
                        bit_cnt  <= BCNT_W'(FRM_W - 1);
                        div_cnt  <= '0;
                        state    <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (!div_end) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        if (!dac_sclk) begin
                            dac_sclk <= 1'b1;       // dac samples here
                        end else begin
                            dac_sclk <= 1'b0;
                            if (bit_cnt == '0) begin
                                dac_csel <= 1'b1;   // end of frame
                                dac_mosi <= 1'b0;
                                state    <= ST_GAP;
                            end else begin
                                dac_mosi <= shift_reg[FRM_W-2];
                                bit_cnt  <= bit_cnt - 1'b1;
                            end
                        end
                    end
                end
                ST_GAP:  state <= ST_IDLE;          // csel high 2 cycles min
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/ctrl_enc.sv
// per-axis input synchronizers, 4x quadrature decoders, counters and preload registers
`timescale 1ns/1ns
`include "qla_macros.svh"

module ctrl_enc
    import qla_pkg::*;
(
    input  logic                        sysclk,
    input  logic                        rst_n,
    input  logic [`QLA_NUM_CHAN-1:0]    enc_a,
    input  logic [`QLA_NUM_CHAN-1:0]    enc_b,
    input  qla_addr_u                   reg_addr,
    input  logic [`QLA_DATA_BITS-1:0]   reg_wdata,
    input  logic                        reg_wen,
    output logic [`QLA_DATA_BITS-1:0]   enc_rdata
);

    localparam int N     = `QLA_NUM_CHAN;
    localparam int CH_W  = `QLA_CHAN_BITS;
    localparam int ENC_W = `QLA_ENC_BITS;
    localparam int EXT_W = `QLA_DATA_BITS - `QLA_ENC_BITS;

    logic [N-1:0]      a_s1, a_s2, a_d;     // sync pair + last decoded state
    logic [N-1:0]      b_s1, b_s2, b_d;
    logic [N-1:0]      a_chg, b_chg;
    logic [N-1:0]      ab_diff;
    logic [N-1:0]      cnt_up, cnt_dn;

    logic [ENC_W-1:0]  enc_cnt [N];
    logic [ENC_W-1:0]  enc_pre [N];
    logic [CH_W-1:0]   sel_ch;
    logic              pre_wr;
    logic [ENC_W-1:0]  sel_cnt;

    // --------------------
    // synchronizers
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            a_s1 <= '0;
            a_s2 <= '0;
            a_d  <= '0;
            b_s1 <= '0;
            b_s2 <= '0;
            b_d  <= '0;
        end else begin
            a_s1 <= enc_a;
            a_s2 <= a_s1;
            a_d  <= a_s2;                   // moves with the count update
            b_s1 <= enc_b;
            b_s2 <= b_s1;
            b_d  <= b_s2;
        end
    end

    // --------------------
    // 4x decode
    // --------------------
    // a leads b: 00 -> 10 -> 11 -> 01 -> 00 counts up
    assign a_chg   = a_s2 ^ a_d;
    assign b_chg   = b_s2 ^ b_d;
    assign ab_diff = a_s2 ^ b_s2;

    assign cnt_up = (a_chg & ~b_chg & ab_diff) | (b_chg & ~a_chg & ~ab_diff);
    assign cnt_dn = (a_chg & ~b_chg & ~ab_diff) | (b_chg & ~a_chg & ab_diff);
    // both changed -> neither up nor down, step dropped

    // --------------------
    // counters, preload
    // --------------------
    assign sel_ch = axis_index(reg_addr);
    assign pre_wr = reg_wen && axis_valid(reg_addr) && (reg_addr.axis.dev == `QLA_DEV_PRELOAD);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                enc_cnt[i] <= '0;
                enc_pre[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (pre_wr && (sel_ch == CH_W'(i))) begin
                    enc_pre[i] <= reg_wdata[ENC_W-1:0];
                    enc_cnt[i] <= reg_wdata[ENC_W-1:0];     // preload beats a step
                end else if (cnt_up[i]) begin
                    enc_cnt[i] <= enc_cnt[i] + 1'b1;
                end else if (cnt_dn[i]) begin
                    enc_cnt[i] <= enc_cnt[i] - 1'b1;
                end
            end
        end
    end

    // --------------------
    // readback
    // --------------------
    assign sel_cnt = enc_cnt[sel_ch];

    always_comb begin
        enc_rdata = '0;
        if (axis_valid(reg_addr)) begin
            if (reg_addr.axis.dev == `QLA_DEV_PRELOAD) begin
                enc_rdata = {{EXT_W{1'b0}}, enc_pre[sel_ch]};
            end else if (reg_addr.axis.dev == `QLA_DEV_QUAD) begin
                enc_rdata = {{EXT_W{sel_cnt[ENC_W-1]}}, sel_cnt};   // sign-extend
            end
        end
    end

endmodule

// File: source/qla_macros.svh
// board sizes, field widths, device codes, dac command and board identifier
`ifndef QLA_MACROS_SVH
`define QLA_MACROS_SVH

// --------------------
// sizes
// --------------------
`define QLA_NUM_CHAN        4           // motor axes, channels 1..4
`define QLA_CHAN_BITS       2           // axis index 0..3
`define QLA_ADDR_BITS       8           // chan nibble + dev nibble
`define QLA_DATA_BITS       32          // host bus word

`define QLA_DAC_BITS        16          // setpoint width
`define QLA_DAC_FRAME_BITS  24          // cmd(4) + chan(4) + setpoint(16)
`define QLA_ENC_BITS        24          // quad count, sign-extended on read

// --------------------
// address decode
// --------------------
// axis view, low nibble
`define QLA_DEV_DAC         4'd1
`define QLA_DEV_PRELOAD     4'd4
`define QLA_DEV_QUAD        4'd5

// board view (channel 0), low nibble
`define QLA_BREG_STATUS     4'd0
`define QLA_BREG_ID         4'd4

`define QLA_BOARD_ID_WORD   32'h514C_4131   // "QLA1"
`define QLA_DAC_CMD         4'b0011         // write-and-update, top of frame

`endif

// File: source/qla_pkg.sv
// register address union with its two views, plus axis decode helpers
`include "qla_macros.svh"

package qla_pkg;

    // one 8-bit address word, decoded per channel
    typedef union packed {
        struct packed {
            logic [3:0] chan;           // 1..4 are axes
            logic [3:0] dev;            // dac, preload, quad ...
        } axis;
        struct packed {
            logic [3:0] zero;           // channel 0 only
            logic [3:0] idx;            // board register index
        } board;
    } qla_addr_u;

    // true for channels 1..4
    function automatic logic axis_valid(qla_addr_u a);
        return (a.axis.chan >= 4'd1) && (a.axis.chan <= 4'(`QLA_NUM_CHAN));
    endfunction

    // channel 1..4 -> index 0..3
    function automatic logic [`QLA_CHAN_BITS-1:0] axis_index(qla_addr_u a);
        return `QLA_CHAN_BITS'(a.axis.chan - 4'd1);
    endfunction

endpackage

// File: source/qla_top.sv
// motor controller register core top level, bus and board pins to the three controllers
`timescale 1ns/1ns
`include "qla_macros.svh"

module qla_top (
    input  logic                        sysclk,
    input  logic                        rst_n,

    // host register bus
    input  logic [`QLA_ADDR_BITS-1:0]   reg_addr,
    input  logic [`QLA_DATA_BITS-1:0]   reg_wdata,
    input  logic                        reg_wen,
    output logic [`QLA_DATA_BITS-1:0]   reg_rdata,

    // encoders
    input  logic [`QLA_NUM_CHAN-1:0]    enc_a,
    input  logic [`QLA_NUM_CHAN-1:0]    enc_b,

    // board pins
    input  logic [`QLA_NUM_CHAN-1:0]    board_id,
    input  logic [`QLA_NUM_CHAN-1:0]    fault,
    input  logic [`QLA_NUM_CHAN-1:0]    home,
    input  logic [`QLA_NUM_CHAN-1:0]    pos_limit,
    input  logic [`QLA_NUM_CHAN-1:0]    neg_limit,

    // shared dac serial line
    output logic                        dac_sclk,
    output logic                        dac_mosi,
    output logic                        dac_csel,

    output logic [`QLA_NUM_CHAN-1:0]    amp_disable,
    output logic                        pwr_enable,
    output logic                        relay_on
);

    logic [`QLA_DATA_BITS-1:0] dac_rdata;   // to the router
    logic [`QLA_DATA_BITS-1:0] enc_rdata;

    // --------------------
    // dacs
    // --------------------
    ctrl_dac u_dac (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .dac_rdata (dac_rdata),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_csel  (dac_csel)
    );

    // encoders, preload + quad count
    ctrl_enc u_enc (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .enc_rdata (enc_rdata)
    );

    // channel 0, also owns the final read mux
    board_regs u_board (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .board_id    (board_id),
        .fault       (fault),
        .home        (home),
        .pos_limit   (pos_limit),
        .neg_limit   (neg_limit),
        .dac_rdata   (dac_rdata),
        .enc_rdata   (enc_rdata),
        .reg_rdata   (reg_rdata),
        .amp_disable (amp_disable),
        .pwr_enable  (pwr_enable),
        .relay_on    (relay_on)
    );

endmodule
